//--- bench/qpc_access_vectors.txt
# W page base | C type opcode qpn tag | B backpressure (1 on, 0 off)
# all fields hex, type 1 read, 2 write, 3 destroy
W 00 0000000100000000
W 01 00000001a0001000
W 05 0000002000abc000
W 3f ffff0000fff00fff
C 1 1 000 01
C 1 1 003 02
C 1 2 015 03
C 1 1 05a 04
C 2 2 05a 05
C 1 1 3ff 06
C 3 1 010 07
C 1 1 087 08
W 08 0000003300000000
C 1 1 087 09
C 1 2 2c4 0a
B 1
C 1 1 001 10
C 1 1 012 11
C 2 1 013 12
C 1 1 05f 13
C 1 1 3f1 14
C 1 1 2c5 15
C 3 2 000 16
C 1 1 088 17
W 2c 0000004400000000
C 1 1 2c6 18
C 1 1 007 19
B 0
C 1 1 004 1a
C 2 1 004 1b
C 1 1 3fe 1c
C 1 1 016 1d

//--- all.f
hw/cxt_cmd_pkg.sv
hw/icm_pkg.sv
hw/icm_mapping_table.sv
hw/qpc_access_ctl.sv
hw/qpc_get_queue.sv
hw/qpc_access_top.sv
bench/qpc_access_tb.sv

//--- Bender.yml
package:
  name: qpc_access

sources:
  # packages, command fields before icm addressing
  - hw/cxt_cmd_pkg.sv
  - hw/icm_pkg.sv
  # design
  - hw/icm_mapping_table.sv
  - hw/qpc_access_ctl.sv
  - hw/qpc_get_queue.sv
  - hw/qpc_access_top.sv
  # testbench
  - target: test
    files:
      - bench/qpc_access_tb.sv

//--- bench/qpc_access_tb.sv
// qpc access testbench replaying table writes and context commands from a vectors file
`timescale 1ns/1ps
`default_nettype none

module qpc_access_tb;
    import cxt_cmd_pkg::*;
    import icm_pkg::*;

    localparam int qp_num_log    = 10;
    localparam int queue_depth   = 4;
    localparam int page_num      = 1 << (qp_num_log + qpc_slot_shift - icm_page_shift);
    localparam int page_width    = $clog2(page_num);
    localparam int max_ops       = 128;
    localparam int fixed_latency = 4;
    localparam int drive_skew    = 2;
    localparam string vec_path   = "bench/qpc_access_vectors.txt";

    logic                      clk;
    logic                      rst;
    logic                      cxt_req_valid;
    logic [cxt_head_width-1:0] cxt_req_head;
    logic [cxt_data_width-1:0] cxt_req_data;
    logic                      cxt_req_ready;
    logic                      map_wr_en;
    logic [page_width-1:0]     map_wr_page;
    logic [phy_addr_width-1:0] map_wr_phy_base;
    logic                      qpc_get_req_valid;
    logic [get_head_width-1:0] qpc_get_req_head;
    logic                      qpc_get_req_ready;

    // vector storage with one entry per operation line
    logic [7:0]                op_kind [max_ops];
    logic [63:0]               op_a    [max_ops];
    logic [63:0]               op_b    [max_ops];
    logic [63:0]               op_c    [max_ops];
    logic [63:0]               op_d    [max_ops];
    int                        n_ops;
    bit                        ops_loaded;

    // reference page table mirroring every W line
    logic [phy_addr_width-1:0] ref_base    [page_num];
    bit                        ref_written [page_num];
    logic [get_head_width-1:0] exp_q [$];
    logic [get_head_width-1:0] exp_head;

    // bookkeeping
    int  cycle_cnt = 0;
    int  mismatch_cnt = 0;
    int  other_cnt = 0;
    int  got_cnt = 0;
    int  n_reads = 0;
    bit  bp_on;
    bit  lat_pending;
    int  lat_start;
    logic ready_next;

    qpc_access_top #(
        .qp_num_log  (qp_num_log),
        .queue_depth (queue_depth)
    ) DUT (
        .clk               (clk),
        .rst               (rst),
        .cxt_req_valid     (cxt_req_valid),
        .cxt_req_head      (cxt_req_head),
        .cxt_req_data      (cxt_req_data),
        .cxt_req_ready     (cxt_req_ready),
        .map_wr_en         (map_wr_en),
        .map_wr_page       (map_wr_page),
        .map_wr_phy_base   (map_wr_phy_base),
        .qpc_get_req_valid (qpc_get_req_valid),
        .qpc_get_req_head  (qpc_get_req_head),
        .qpc_get_req_ready (qpc_get_req_ready)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // cache side ready is random while back-pressure is on
    always @(posedge clk) begin
        ready_next = bp_on ? (($urandom % 2) != 0) : 1'b1;
        #drive_skew;
        qpc_get_req_ready = ready_next;
    end

    // head layout per the command field positions
    function automatic logic [cxt_head_width-1:0] make_cmd_head(
        input logic [3:0] ctype, input logic [3:0] opcode,
        input logic [qp_num_log-1:0] qpn, input logic [req_tag_width-1:0] tag);
        logic [cxt_head_width-1:0] head;
        head = '0;
        head[type_lsb +: 4]              = ctype;
        head[opcode_lsb +: 4]            = opcode;
        head[qpn_lsb +: qp_num_log]      = qpn;
        head[tag_lsb +: req_tag_width]   = tag;
        return head;
    endfunction

    // slot address and page lookup keep the page offset of the icm address
    function automatic logic [get_head_width-1:0] build_expected_head(
        input logic [qp_num_log-1:0] qpn, input logic [req_tag_width-1:0] tag);
        logic [icm_addr_width-1:0] icm;
        logic [page_width-1:0]     page;
        logic [phy_addr_width-1:0] phy;
        icm  = '0;
        icm[qpc_slot_shift +: qp_num_log] = qpn;
        page = icm[icm_page_shift +: page_width];
        phy  = ref_written[page] ? ref_base[page] : '0;
        phy[icm_page_shift-1:0] = icm[icm_page_shift-1:0];
        return {count_width'(1), count_width'(0), tag, phy, icm};
    endfunction

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    endtask

    // reads W, C and B lines and skips '#' lines
    task automatic load_vectors();
        int          fd;
        int          code;
        int          ch;
        int          nargs;
        bit          done;
        logic [7:0]  kind;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] d;
        n_ops = 0;
        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            $display("Error: cannot open vectors file %s", vec_path);
            other_cnt++;
            return;
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (n_ops >= max_ops) begin
                $display("Error: vectors file holds more than %0d operations", max_ops);
                other_cnt++;
                done = 1'b1;
            end else begin
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                case (kind)
                    "W": begin
                        code  = $fscanf(fd, "%h %h", a, b);
                        nargs = 2;
                    end
                    "C": begin
                        code  = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                        nargs = 4;
                    end
                    "B": begin
                        code  = $fscanf(fd, "%h", a);
                        nargs = 1;
                    end
                    default: begin
                        code  = -1;
                        nargs = 0;
                    end
                endcase
                if (code != nargs) begin
                    $display("Error: bad vector line of kind '%c' after %0d operations",
                             kind, n_ops);
                    other_cnt++;
                    done = 1'b1;
                end else begin
                    op_kind[n_ops] = kind;
                    op_a[n_ops] = a;
                    op_b[n_ops] = b;
                    op_c[n_ops] = c;
                    op_d[n_ops] = d;
                    n_ops++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one-cycle strobe mirrored into the reference table
    task automatic write_page(input logic [page_width-1:0] page, input logic [63:0] base);
        @(posedge clk);
        #drive_skew;
        map_wr_en       = 1'b1;
        map_wr_page     = page;
        map_wr_phy_base = base;
        ref_base[page]    = base;
        ref_written[page] = 1'b1;
        @(posedge clk);
        #drive_skew;
        map_wr_en = 1'b0;
    endtask

    // hold the command until the DUT takes it
    task automatic send_cmd(input logic [cxt_head_width-1:0] head, input int idx);
        @(posedge clk);
        #drive_skew;
        cxt_req_valid = 1'b1;
        cxt_req_head  = head;
        cxt_req_data  = {4{32'(idx)}};
        @(negedge clk);
        while (!cxt_req_ready) @(negedge clk);
        @(posedge clk);
        #drive_skew;
        cxt_req_valid = 1'b0;
        cxt_req_head  = '0;
    endtask

    task automatic set_backpressure(input bit on);
        @(posedge clk);
        #drive_skew;
        bp_on = on;
    endtask

    // sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        if (!rst) begin
            // fixed latency with an idle pipe
            if (lat_pending && qpc_get_req_valid) begin
                assert (cycle_cnt - lat_start == fixed_latency) else begin
                    $display("Mismatch: qpc_get_req_valid latency expected 0x%0h, got 0x%0h",
                             fixed_latency, cycle_cnt - lat_start);
                    mismatch_cnt++;
                end
                lat_pending = 1'b0;
            end
            if (qpc_get_req_valid && qpc_get_req_ready) begin
                got_cnt++;
                assert (exp_q.size() != 0) else begin
                    $display("Error: get request arrived with no read command pending");
                    other_cnt++;
                end
                if (exp_q.size() != 0) begin
                    exp_head = exp_q.pop_front();
                    assert (qpc_get_req_head === exp_head) else begin
                        $display("Mismatch: qpc_get_req_head expected 0x%h, got 0x%h",
                                 exp_head, qpc_get_req_head);
                        mismatch_cnt++;
                    end
                end
            end
            // read commands queue their expected head
            if (cxt_req_valid && cxt_req_ready) begin
                if (cxt_req_head[type_lsb +: 4] == cxt_type_read) begin
                    if (!bp_on && exp_q.size() == 0 && !lat_pending) begin
                        lat_pending = 1'b1;
                        lat_start   = cycle_cnt;
                    end
                    exp_q.push_back(build_expected_head(cxt_req_head[qpn_lsb +: qp_num_log],
                                                        cxt_req_head[tag_lsb +: req_tag_width]));
                end
            end
        end
    end

    // run limit scales with the vector count
    initial begin
        int limit;
        wait (ops_loaded);
        limit = n_ops * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("Error: timeout, run did not finish within %0d cycles", limit);
        report_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int i;
        int seed;
        rst               = 1'b1;
        cxt_req_valid     = 1'b0;
        cxt_req_head      = '0;
        cxt_req_data      = '0;
        map_wr_en         = 1'b0;
        map_wr_page       = '0;
        map_wr_phy_base   = '0;
        qpc_get_req_ready = 1'b1;
        bp_on             = 1'b0;
        lat_pending       = 1'b0;
        lat_start         = 0;
        seed = $urandom(27450);
        load_vectors();
        ops_loaded = 1'b1;

        // reset for 2 cycles
        repeat (2) @(posedge clk);
        #drive_skew;
        rst = 1'b0;

        // idle state right after reset
        @(negedge clk);
        assert (cxt_req_ready === 1'b1) else begin
            $display("Mismatch: cxt_req_ready expected 0x1, got 0x%h", cxt_req_ready);
            mismatch_cnt++;
        end
        assert (qpc_get_req_valid === 1'b0) else begin
            $display("Mismatch: qpc_get_req_valid expected 0x0, got 0x%h", qpc_get_req_valid);
            mismatch_cnt++;
        end

        for (i = 0; i < n_ops; i++) begin
            case (op_kind[i])
                "W": write_page(op_a[i][page_width-1:0], op_b[i]);
                "C": begin
                    // reads in the vectors set the expected get count
                    if (op_a[i][3:0] == cxt_type_read) begin
                        n_reads++;
                    end
                    send_cmd(make_cmd_head(op_a[i][3:0], op_b[i][3:0],
                                           op_c[i][qp_num_log-1:0],
                                           op_d[i][req_tag_width-1:0]), i);
                end
                default: set_backpressure(op_a[i][0]);
            endcase
        end

        // drain and wait a few idle cycles to catch stray requests
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (got_cnt == n_reads) else begin
            $display("Mismatch: get request count expected 0x%h, got 0x%h", n_reads, got_cnt);
            mismatch_cnt++;
        end

        report_counts();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/qpc_access_top.sv
// qpc access top: controller, icm mapping table and get queue
`timescale 1ns/1ps
`default_nettype none

module qpc_access_top #(
    parameter int  qp_num_log   = 10,
    parameter int  queue_depth  = 4,
    // pages needed to cover every qpc slot
    localparam int icm_page_num = 1 << (qp_num_log + icm_pkg::qpc_slot_shift
                                        - icm_pkg::icm_page_shift),
    localparam int page_width   = (icm_page_num > 1) ? $clog2(icm_page_num) : 1
) (
    input  wire                                    clk,
    input  wire                                    rst,

    // context commands
    input  wire                                    cxt_req_valid,
    input  wire  [cxt_cmd_pkg::cxt_head_width-1:0] cxt_req_head,
    input  wire  [cxt_cmd_pkg::cxt_data_width-1:0] cxt_req_data,
    output logic                                   cxt_req_ready,

    // mapping table writes from software
    input  wire                                    map_wr_en,
    input  wire  [page_width-1:0]                  map_wr_page,
    input  wire  [icm_pkg::phy_addr_width-1:0]     map_wr_phy_base,

    // qpc get requests to the cache
    output logic                                   qpc_get_req_valid,
    output logic [icm_pkg::get_head_width-1:0]     qpc_get_req_head,
    input  wire                                    qpc_get_req_ready
);
    import icm_pkg::*;

    // controller <-> table
    logic                      lookup_valid;
    logic [qp_num_log-1:0]     lookup_qpn;
    logic                      lookup_ready;
    logic                      rsp_valid;
    logic [icm_addr_width-1:0] rsp_icm_addr;
    logic [phy_addr_width-1:0] rsp_phy_addr;
    logic                      rsp_ready;

    // controller -> queue
    logic                      get_valid;
    logic [get_head_width-1:0] get_head;
    logic                      get_ready;

    qpc_access_ctl #(
        .qp_num_log (qp_num_log)
    ) u_ctl (
        .clk           (clk),
        .rst           (rst),
        .cxt_req_valid (cxt_req_valid),
        .cxt_req_head  (cxt_req_head),
        .cxt_req_data  (cxt_req_data),
        .cxt_req_ready (cxt_req_ready),
        .lookup_valid  (lookup_valid),
        .lookup_qpn    (lookup_qpn),
        .lookup_ready  (lookup_ready),
        .rsp_valid     (rsp_valid),
        .rsp_icm_addr  (rsp_icm_addr),
        .rsp_phy_addr  (rsp_phy_addr),
        .rsp_ready     (rsp_ready),
        .get_valid     (get_valid),
        .get_head      (get_head),
        .get_ready     (get_ready)
    );

    icm_mapping_table #(
        .qp_num_log   (qp_num_log),
        .icm_page_num (icm_page_num)
    ) u_map (
        .clk             (clk),
        .rst             (rst),
        .map_wr_en       (map_wr_en),
        .map_wr_page     (map_wr_page),
        .map_wr_phy_base (map_wr_phy_base),
        .lookup_valid    (lookup_valid),
        .lookup_qpn      (lookup_qpn),
        .lookup_ready    (lookup_ready),
        .rsp_valid       (rsp_valid),
        .rsp_icm_addr    (rsp_icm_addr),
        .rsp_phy_addr    (rsp_phy_addr),
        .rsp_ready       (rsp_ready)
    );

    // absorbs cache back-pressure
    qpc_get_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (get_valid),
        .in_head   (get_head),
        .in_ready  (get_ready),
        .out_valid (qpc_get_req_valid),
        .out_head  (qpc_get_req_head),
        .out_ready (qpc_get_req_ready)
    );

endmodule

`default_nettype wire

//--- hw/qpc_get_queue.sv
// qpc get queue holding get-request heads toward the context cache in a shallow fifo
`timescale 1ns/1ps
`default_nettype none

module qpc_get_queue #(
    parameter int  queue_depth = 4,
    localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1,
    localparam int cnt_width   = $clog2(queue_depth + 1)
) (
    input  wire                                clk,
    input  wire                                rst,

    // write side from the controller
    input  wire                                in_valid,
    input  wire  [icm_pkg::get_head_width-1:0] in_head,
    output logic                               in_ready,

    // read side toward the cache
    output logic                               out_valid,
    output logic [icm_pkg::get_head_width-1:0] out_head,
    input  wire                                out_ready
);
    import icm_pkg::*;

    logic [get_head_width-1:0] mem [queue_depth];
    logic [ptr_width-1:0]      wr_ptr;
    logic [ptr_width-1:0]      rd_ptr;
    logic [cnt_width-1:0]      count;
    logic                      full;
    logic                      empty;
    logic                      wr_en;
    logic                      rd_en;

    // wrap at depth so non power of two depths work too
    function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] p);
        if (p == ptr_width'(queue_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full  = (count == cnt_width'(queue_depth));
    assign empty = (count == '0);

    // full queue still takes a write if a read leaves the same cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = !empty;
    assign out_head  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_head;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // occupancy
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // occupancy never goes past the depth
    no_overflow_a: assert property (@(posedge clk) disable iff (rst)
        count <= cnt_width'(queue_depth))
        else $error("qpc_get_queue: occupancy above queue depth");

    // empty queue without a write stays empty, no wrap below zero
    no_underflow_a: assert property (@(posedge clk) disable iff (rst)
        empty && !wr_en |=> empty)
        else $error("qpc_get_queue: read from an empty queue");

endmodule

`default_nettype wire

//--- hw/qpc_access_ctl.sv
// qpc access controller that takes a context command, translates its qpn and issues one qpc get
`timescale 1ns/1ps
`default_nettype none

module qpc_access_ctl #(
    parameter int qp_num_log = 10
) (
    input  wire                                    clk,
    input  wire                                    rst,

    // context command in
    input  wire                                    cxt_req_valid,
    input  wire  [cxt_cmd_pkg::cxt_head_width-1:0] cxt_req_head,
    // data word is not needed for a qpc read
    input  wire  [cxt_cmd_pkg::cxt_data_width-1:0] cxt_req_data,
    output logic                                   cxt_req_ready,

    // lookup toward the mapping table
    output logic                                   lookup_valid,
    output logic [qp_num_log-1:0]                  lookup_qpn,
    input  wire                                    lookup_ready,

    // translated addresses back
    input  wire                                    rsp_valid,
    input  wire  [icm_pkg::icm_addr_width-1:0]     rsp_icm_addr,
    input  wire  [icm_pkg::phy_addr_width-1:0]     rsp_phy_addr,
    output logic                                   rsp_ready,

    // get request toward the queue
    output logic                                   get_valid,
    output logic [icm_pkg::get_head_width-1:0]     get_head,
    input  wire                                    get_ready
);
    import cxt_cmd_pkg::*;
    import icm_pkg::*;

    typedef enum logic [1:0] {
        idle_s,
        addr_req_s,
        addr_rsp_s,
        qpc_get_s
    } state_e;

    // single sub-request per context command
    localparam logic [count_width-1:0] count_total = count_width'(1);
    localparam logic [count_width-1:0] count_index = '0;

    state_e state;
    state_e state_nxt;

    // command side
    logic                      cmd_fire;
    cxt_type_e                 cmd_type;
    logic [cxt_head_width-1:0] head_q;

    // get head fields
    logic [req_tag_width-1:0]  req_tag;
    logic [phy_addr_width-1:0] phy_addr;
    logic [icm_addr_width-1:0] icm_addr;

    // only accept in idle
    assign cxt_req_ready = (state == idle_s);
    assign cmd_fire      = cxt_req_valid && cxt_req_ready;

    // type decided straight from the incoming head
    assign cmd_type = cxt_type_e'(cxt_req_head[type_lsb +: $bits(cxt_type_e)]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle_s;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle_s: begin
                // write and destroy fall through and stay idle
                if (cmd_fire && cmd_type == cxt_type_read) begin
                    state_nxt = addr_req_s;
                end
            end
            addr_req_s: begin
                if (lookup_ready) begin
                    state_nxt = addr_rsp_s;
                end
            end
            addr_rsp_s: begin
                if (rsp_valid) begin
                    state_nxt = qpc_get_s;
                end
            end
            qpc_get_s: begin
                // wait here while the queue is full
                if (get_ready) begin
                    state_nxt = idle_s;
                end
            end
            default: begin
                state_nxt = idle_s;
            end
        endcase
    end

    // head latched on acceptance
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            head_q <= cxt_req_head;
        end
    end

    // lookup phase
    assign lookup_valid = (state == addr_req_s);
    assign lookup_qpn   = head_q[qpn_lsb +: qp_num_log];

    // response always taken in addr_rsp_s
    assign rsp_ready = (state == addr_rsp_s);

    // tag and address pair captured as the response transfers
    always_ff @(posedge clk) begin
        if (state == addr_rsp_s && rsp_valid) begin
            req_tag  <= head_q[tag_lsb +: req_tag_width];
            phy_addr <= rsp_phy_addr;
            icm_addr <= rsp_icm_addr;
        end
    end

    assign get_valid = (state == qpc_get_s);
    assign get_head  = get_valid ? {count_total, count_index, req_tag, phy_addr, icm_addr}
                                 : '0;

    // get request holds until the queue takes it
    get_hold_a: assert property (@(posedge clk) disable iff (rst)
        get_valid && !get_ready |=> get_valid && $stable(get_head))
        else $error("qpc_access_ctl: get request dropped or changed before get_ready");

    // get request only follows a taken lookup response and never overlaps the lookup
    get_after_rsp_a: assert property (@(posedge clk) disable iff (rst)
        $rose(get_valid) |-> $past(rsp_valid && rsp_ready))
        else $error("qpc_access_ctl: get_valid rose without a lookup response");

endmodule

`default_nettype wire

//--- hw/icm_mapping_table.sv
// icm mapping table: icm page to host physical page, sw write port and qpn translate port
`timescale 1ns/1ps
`default_nettype none

module icm_mapping_table #(
    parameter int  qp_num_log   = 10,
    parameter int  icm_page_num = 64,
    localparam int page_width   = (icm_page_num > 1) ? $clog2(icm_page_num) : 1
) (
    input  wire                                clk,
    input  wire                                rst,

    // software write strobe
    input  wire                                map_wr_en,
    input  wire  [page_width-1:0]              map_wr_page,
    input  wire  [icm_pkg::phy_addr_width-1:0] map_wr_phy_base,

    // lookup request
    input  wire                                lookup_valid,
    input  wire  [qp_num_log-1:0]              lookup_qpn,
    output logic                               lookup_ready,

    // lookup response
    output logic                               rsp_valid,
    output logic [icm_pkg::icm_addr_width-1:0] rsp_icm_addr,
    output logic [icm_pkg::phy_addr_width-1:0] rsp_phy_addr,
    input  wire                                rsp_ready
);
    import icm_pkg::*;

    // page base per icm page, plus written flags
    logic [phy_addr_width-1:0] page_base [icm_page_num];
    logic [icm_page_num-1:0]   page_written;

    // translate path
    logic                      lookup_fire;
    logic [icm_addr_width-1:0] icm_addr;
    logic [page_width-1:0]     page_idx;
    logic [phy_addr_width-1:0] base_sel;
    logic [phy_addr_width-1:0] phy_addr;

    // one lookup in flight, new one only once response is gone
    assign lookup_ready = !rsp_valid;
    assign lookup_fire  = lookup_valid && lookup_ready;

    // qpn scaled by the slot size gives the icm address
    assign icm_addr = icm_addr_width'(lookup_qpn) << qpc_slot_shift;

    // page number of that address
    assign page_idx = page_width'(icm_addr >> icm_page_shift);

    // never written -> base zero
    assign base_sel = page_written[page_idx] ? page_base[page_idx] : '0;

    // page base with in-page offset from the icm address
    assign phy_addr = {base_sel[phy_addr_width-1:icm_page_shift],
                       icm_addr[icm_page_shift-1:0]};

    // software table writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < icm_page_num; i++) begin
                page_base[i] <= '0;
            end
            page_written <= '0;
        end else if (map_wr_en) begin
            page_base[map_wr_page]    <= map_wr_phy_base;
            page_written[map_wr_page] <= 1'b1;
        end
    end

    // response valid, held until taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (lookup_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // translated pair, loaded only on an accepted lookup
    always_ff @(posedge clk) begin
        if (lookup_fire) begin
            rsp_icm_addr <= icm_addr;
            rsp_phy_addr <= phy_addr;
        end
    end

    // pending response must not move or drop before the controller takes it
    rsp_hold_a: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=>
            rsp_valid && $stable(rsp_icm_addr) && $stable(rsp_phy_addr))
        else $error("icm_mapping_table: response changed before rsp_ready");

endmodule

`default_nettype wire

//--- hw/icm_pkg.sv
// icm addressing package: page and slot geometry, address and get-head widths
`default_nettype none

package icm_pkg;

    // icm virtual address
    localparam int icm_addr_width = 64;

    // host physical address
    localparam int phy_addr_width = 64;

    // 4 KiB icm pages
    localparam int icm_page_shift = 12;

    // 256 bytes per qpc entry
    localparam int qpc_slot_shift = 8;

    // translated pair as returned by the mapping table
    // icm address plus physical address
    localparam int xlate_pair_width = icm_addr_width + phy_addr_width;

    // get-request head, msb first:
    // count_total, count_index, tag, physical address, icm address
    localparam int get_head_width = 2 * cxt_cmd_pkg::count_width
                                  + cxt_cmd_pkg::req_tag_width
                                  + xlate_pair_width;

endpackage

`default_nettype wire

//--- hw/cxt_cmd_pkg.sv
// context command package: head field layout, command type and opcode codes
`default_nettype none

package cxt_cmd_pkg;

    // command head, one word
    localparam int cxt_head_width = 64;

    // command data word, one word
    localparam int cxt_data_width = 128;

    // request tag sits in the low byte of the head
    localparam int req_tag_width = 8;

    // field positions inside the head
    localparam int type_lsb   = 60;
    localparam int opcode_lsb = 56;
    localparam int qpn_lsb    = 12;
    localparam int tag_lsb    = 0;

    // sub-request count fields of a get-request head
    // total and index, one each
    localparam int count_width = 2;

    // command type, head bits [63:60]
    typedef enum logic [3:0] {
        cxt_type_read    = 4'h1,
        cxt_type_write   = 4'h2,
        cxt_type_destroy = 4'h3
    } cxt_type_e;

    // opcode, head bits [59:56]
    // passed along with the command, not decoded here
    typedef enum logic [3:0] {
        op_qpc_query  = 4'h1,
        op_qpc_modify = 4'h2
    } cxt_opcode_e;

endpackage

`default_nettype wire
